// ==== fetchPkg.sv ====
package fetchPkg;

    // one 16-bit instruction word as it sits in memory
    typedef struct packed {
        logic [4:0] opCode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] shamt;
    } instrWord;

    // opcode encodings seen by the front end
    typedef enum logic [4:0] {
        opNop       = 5'b00000,
        opAdd       = 5'b00001,
        opSub       = 5'b00010,
        opShl       = 5'b00011,
        opShr       = 5'b00100,
        opJmp       = 5'b01000,
        // two-word form with the immediate in the following word
        opLdm       = 5'b10100,
        // stack codes injected by the fetch stage
        opPushPc    = 5'b11011,
        opPopPc     = 5'b11101,
        opPushFlags = 5'b11111
    } opCodeE;

    // pc redirect request
    typedef struct packed {
        logic        interrupt;
        logic        ret;
        logic        jump;
        logic [31:0] jumpAddress;
        // return target from the stack
        logic [31:0] popAddress;
    } redirectT;

    // stack instruction requests
    typedef struct packed {
        logic pushFlags;
        logic pushPc;
        logic popPc;
    } stackReqT;

    // decoder result
    typedef struct packed {
        opCodeE      opCode;
        logic [2:0]  rs;
        logic [2:0]  rd;
        logic [4:0]  shamt;
        logic [15:0] immediate;
        logic        hasImmediate;
        // address of the opcode word
        logic [31:0] pc;
    } decodedT;

endpackage

// ==== instructionMemory.sv ====
`timescale 1ns/1ps

module instructionMemory #(
    parameter int memWords = 32
) (
    input  logic               clk,
    input  logic [31:0]        addr,
    output fetchPkg::instrWord word
);
    import fetchPkg::*;

    // index width for the word array
    localparam int idxWidth = (memWords > 1) ? $clog2(memWords) : 1;

    // program image, read only
    instrWord memArray [memWords];

    logic [idxWidth-1:0] index;

    // image comes from the hex file once at start
    initial begin
        $readmemh("program.hex", memArray);
    end

    // pc wraps over the image
    assign index = idxWidth'(addr % memWords);

    // combinational read in the same cycle as the address
    assign word = memArray[index];

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
    parameter logic [31:0] resetVector     = 32'h0000_0020,
    parameter logic [31:0] interruptVector = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               enable,
    input  fetchPkg::redirectT redirect,
    input  fetchPkg::stackReqT stackReq,
    input  logic [2:0]         stackReg,
    input  fetchPkg::instrWord memWord,
    input  logic               full,
    output logic [31:0]        pc,
    output logic               push,
    output fetchPkg::instrWord pushWord,
    output logic [31:0]        pushPc,
    output logic               flush
);
    import fetchPkg::*;

    logic        redirectAny;
    logic        stackAny;
    opCodeE      stackOp;
    logic [31:0] seqPc;
    logic [31:0] nextPc;

    // any redirect strobe
    assign redirectAny = redirect.interrupt | redirect.ret | redirect.jump;

    // any stack request
    assign stackAny = stackReq.pushFlags | stackReq.pushPc | stackReq.popPc;

    // queue is cleared in the redirect cycle
    assign flush = redirectAny;

    // one push per edge unless redirecting or full
    assign push = ~redirectAny & ~full;

    // pc travels with the word
    // injected words carry the held pc
    assign pushPc = pc;

    // sequential fetch, one word per step
    assign seqPc = pc + 32'd1;

    // stack opcode by fixed priority
    always_comb begin
        if (stackReq.pushFlags) begin
            stackOp = opPushFlags;
        end else if (stackReq.pushPc) begin
            stackOp = opPushPc;
        end else begin
            stackOp = opPopPc;
        end
    end

    // synthetic stack word replaces the memory word
    always_comb begin
        if (stackAny) begin
            pushWord = '{
                opCode: stackOp,
                rs:     stackReg,
                rd:     3'b000,
                shamt:  5'b00000
            };
        end else begin
            pushWord = memWord;
        end
    end

    // next pc chain
    // interrupt first, then return, then jump
    always_comb begin
        if (redirect.interrupt) begin
            nextPc = interruptVector;
        end else if (redirect.ret) begin
            nextPc = redirect.popAddress;
        end else if (redirect.jump) begin
            nextPc = redirect.jumpAddress;
        end else if (full) begin
            // back-pressure holds fetch
            nextPc = pc;
        end else if (stackAny) begin
            // memory word at this pc comes next cycle
            nextPc = pc;
        end else begin
            nextPc = seqPc;
        end
    end

    // program counter
    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            pc <= resetVector;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== fetchQueue.sv ====
`timescale 1ns/1ps

module fetchQueue #(
    parameter int queueDepth = 4
) (
    input  logic                               clk,
    input  logic                               enable,
    input  logic                               push,
    input  fetchPkg::instrWord                 pushWord,
    input  logic [31:0]                        pushPc,
    input  logic                               pop,
    input  logic                               flush,
    output fetchPkg::instrWord                 headWord,
    output logic [31:0]                        headPc,
    output logic                               full,
    output logic                               empty,
    output logic [$clog2(queueDepth + 1)-1:0] count
);
    import fetchPkg::*;

    localparam int ptrWidth   = $clog2(queueDepth);
    localparam int countWidth = $clog2(queueDepth + 1);

    // word and its address stored together
    typedef struct packed {
        instrWord    word;
        logic [31:0] pc;
    } entryT;

    entryT entries [queueDepth];

    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic                doPush;
    logic                doPop;
    entryT               head;

    // occupancy flags
    assign full  = (count == countWidth'(queueDepth));
    assign empty = (count == '0);

    // flush overrides both sides
    assign doPush = push & ~full & ~flush;
    assign doPop  = pop & ~empty & ~flush;

    // oldest entry
    assign head     = entries[rdPtr];
    assign headWord = head.word;
    assign headPc   = head.pc;

    // pointers and count
    // power-of-two depth lets pointers wrap on their own
    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= '{word: pushWord, pc: pushPc};
        end
    end

endmodule

// ==== instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder #(
    parameter int queueDepth = 4
) (
    input  logic                               clk,
    input  logic                               enable,
    input  logic                               stall,
    input  fetchPkg::instrWord                 headWord,
    input  logic [31:0]                        headPc,
    input  logic                               empty,
    input  logic [$clog2(queueDepth + 1)-1:0] count,
    input  logic                               flush,
    output logic                               pop,
    output fetchPkg::decodedT                  out,
    output logic                               outValid
);
    import fetchPkg::*;

    // opcode word next, or the immediate after ldm
    typedef enum logic {
        expectOp,
        expectImm
    } decStateE;

    decStateE state;
    opCodeE   headOp;
    logic     pairReady;

    assign headOp = opCodeE'(headWord.opCode);

    // both words of an ldm pair are queued
    assign pairReady = (count >= 2);

    // pop request
    // ldm opcode only leaves once its immediate is behind it
    always_comb begin
        pop = 1'b0;
        if (!stall && !flush && !empty) begin
            if (state == expectImm) begin
                pop = 1'b1;
            end else begin
                pop = (headOp != opLdm) || pairReady;
            end
        end
    end

    // state and valid pulse
    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            state    <= expectOp;
            outValid <= 1'b0;
        end else if (flush) begin
            // half-taken pair is dropped
            state    <= expectOp;
            outValid <= 1'b0;
        end else begin
            outValid <= 1'b0;
            if (pop) begin
                if (state == expectImm) begin
                    state    <= expectOp;
                    outValid <= 1'b1;
                end else if (headOp == opLdm) begin
                    state <= expectImm;
                end else begin
                    outValid <= 1'b1;
                end
            end
        end
    end

    // decoded fields
    always_ff @(posedge clk) begin
        if (pop) begin
            if (state == expectImm) begin
                // whole second word is the immediate
                out.immediate    <= headWord;
                out.hasImmediate <= 1'b1;
            end else begin
                out.opCode       <= headOp;
                out.rs           <= headWord.rs;
                out.rd           <= headWord.rd;
                out.shamt        <= headWord.shamt;
                out.pc           <= headPc;
                out.immediate    <= '0;
                out.hasImmediate <= 1'b0;
            end
        end
    end

endmodule

// ==== fetchTop.sv ====
`timescale 1ns/1ps

module fetchTop #(
    parameter logic [31:0] resetVector     = 32'h0000_0020,
    parameter logic [31:0] interruptVector = 32'h0000_0000,
    parameter int          queueDepth      = 4,
    parameter int          memWords        = 32
) (
    input  logic               clk,
    input  logic               enable,
    input  fetchPkg::redirectT redirect,
    input  fetchPkg::stackReqT stackReq,
    input  logic [2:0]         stackReg,
    input  logic               stall,
    output fetchPkg::decodedT  out,
    output logic               outValid
);
    import fetchPkg::*;

    localparam int countWidth = $clog2(queueDepth + 1);

    // fetch to memory
    logic [31:0] pc;
    instrWord    memWord;

    // fetch to queue
    logic        push;
    instrWord    pushWord;
    logic [31:0] pushPc;
    logic        flush;
    logic        full;

    // queue to decoder
    logic                  pop;
    logic                  empty;
    instrWord              headWord;
    logic [31:0]           headPc;
    logic [countWidth-1:0] count;

    instructionMemory #(
        .memWords(memWords)
    ) instructionMemory_i (
        .clk (clk),
        .addr(pc),
        .word(memWord)
    );

    fetchStage #(
        .resetVector    (resetVector),
        .interruptVector(interruptVector)
    ) fetchStage_i (
        .clk     (clk),
        .enable  (enable),
        .redirect(redirect),
        .stackReq(stackReq),
        .stackReg(stackReg),
        .memWord (memWord),
        .full    (full),
        .pc      (pc),
        .push    (push),
        .pushWord(pushWord),
        .pushPc  (pushPc),
        .flush   (flush)
    );

    fetchQueue #(
        .queueDepth(queueDepth)
    ) fetchQueue_i (
        .clk     (clk),
        .enable  (enable),
        .push    (push),
        .pushWord(pushWord),
        .pushPc  (pushPc),
        .pop     (pop),
        .flush   (flush),
        .headWord(headWord),
        .headPc  (headPc),
        .full    (full),
        .empty   (empty),
        .count   (count)
    );

    instructionDecoder #(
        .queueDepth(queueDepth)
    ) instructionDecoder_i (
        .clk     (clk),
        .enable  (enable),
        .stall   (stall),
        .headWord(headWord),
        .headPc  (headPc),
        .empty   (empty),
        .count   (count),
        .flush   (flush),
        .pop     (pop),
        .out     (out),
        .outValid(outValid)
    );

endmodule

// ==== fetchTb.sv ====
`timescale 1ns/1ps

module fetchTb;
    import fetchPkg::*;

    localparam logic [31:0] resetVector     = 32'h0000_0020;
    localparam logic [31:0] interruptVector = 32'h0000_0000;
    localparam int          queueDepth      = 4;
    localparam int          memWords        = 32;
    localparam int          randomCycles    = 3000;
    localparam int          waitLimit       = 50;

    // queued word with its fetch address
    typedef struct packed {
        instrWord    word;
        logic [31:0] pc;
    } slotT;

    logic       clk;
    logic       enable;
    redirectT   redirect;
    stackReqT   stackReq;
    logic [2:0] stackReg;
    logic       stall;
    decodedT    out;
    logic       outValid;

    // reference model state
    logic [15:0] image [memWords];
    slotT        modelQ [$];
    logic [31:0] modelPc;
    logic        modelHalf;
    decodedT     modelHold;
    decodedT     expOut;
    logic        expValid;
    logic        stackTaken;

    int checkErrors;
    int timeoutErrors;
    int stallLeft;
    int ldmSeen;
    int stackSeen;

    fetchTop #(
        .resetVector    (resetVector),
        .interruptVector(interruptVector),
        .queueDepth     (queueDepth),
        .memWords       (memWords)
    ) fetchTop_i (
        .clk     (clk),
        .enable  (enable),
        .redirect(redirect),
        .stackReq(stackReq),
        .stackReg(stackReg),
        .stall   (stall),
        .out     (out),
        .outValid(outValid)
    );

    always #4 clk = ~clk;

    // model gets its own copy of the image
    initial begin
        $readmemh("program.hex", image);
    end

    // one clock edge of the model on the inputs held before it
    task automatic modelEdge();
        logic       doFlush;
        logic       isFull;
        logic       stackAny;
        logic       doPop;
        logic [4:0] stackOp;
        slotT       head;
        instrWord   pushed;
        doFlush  = redirect.interrupt | redirect.ret | redirect.jump;
        isFull   = (modelQ.size() == queueDepth);
        stackAny = stackReq.pushFlags | stackReq.pushPc | stackReq.popPc;
        expValid = 1'b0;
        doPop    = 1'b0;
        // decoder side where ldm waits for its partner word
        if (!stall && !doFlush && modelQ.size() > 0) begin
            head = modelQ[0];
            if (modelHalf) begin
                doPop = 1'b1;
            end else begin
                doPop = (head.word.opCode != opLdm) || (modelQ.size() >= 2);
            end
        end
        if (doPop) begin
            if (modelHalf) begin
                expOut              = modelHold;
                expOut.immediate    = head.word;
                expOut.hasImmediate = 1'b1;
                expValid            = 1'b1;
                modelHalf           = 1'b0;
            end else begin
                modelHold.opCode       = opCodeE'(head.word.opCode);
                modelHold.rs           = head.word.rs;
                modelHold.rd           = head.word.rd;
                modelHold.shamt        = head.word.shamt;
                modelHold.immediate    = '0;
                modelHold.hasImmediate = 1'b0;
                modelHold.pc           = head.pc;
                if (head.word.opCode == opLdm) begin
                    modelHalf = 1'b1;
                end else begin
                    expOut   = modelHold;
                    expValid = 1'b1;
                end
            end
            void'(modelQ.pop_front());
        end
        // fetch side
        stackTaken = stackAny && !doFlush && !isFull;
        if (doFlush) begin
            modelQ.delete();
            modelHalf = 1'b0;
        end else if (!isFull) begin
            if (stackAny) begin
                if (stackReq.pushFlags) begin
                    stackOp = opPushFlags;
                end else if (stackReq.pushPc) begin
                    stackOp = opPushPc;
                end else begin
                    stackOp = opPopPc;
                end
                pushed = '{opCode: stackOp, rs: stackReg, rd: 3'b000, shamt: 5'b00000};
            end else begin
                pushed = image[modelPc % memWords];
            end
            modelQ.push_back('{word: pushed, pc: modelPc});
        end
        // next pc with interrupt over ret over jump
        if (redirect.interrupt) begin
            modelPc = interruptVector;
        end else if (redirect.ret) begin
            modelPc = redirect.popAddress;
        end else if (redirect.jump) begin
            modelPc = redirect.jumpAddress;
        end else if (!isFull && !stackAny) begin
            modelPc = modelPc + 32'd1;
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            checkErrors++;
            $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic checkOutputs();
        assert (outValid === expValid) else begin
            checkErrors++;
            $display("CHECK FAILED t=%0t outValid expected %0b actual %0b",
                     $time, expValid, outValid);
        end
        if (expValid && outValid) begin
            checkField("opCode", expOut.opCode, out.opCode);
            checkField("rs", expOut.rs, out.rs);
            checkField("rd", expOut.rd, out.rd);
            checkField("shamt", expOut.shamt, out.shamt);
            checkField("immediate", expOut.immediate, out.immediate);
            checkField("hasImmediate", expOut.hasImmediate, out.hasImmediate);
            checkField("pc", expOut.pc, out.pc);
            if (expOut.hasImmediate) begin
                ldmSeen++;
            end
            if (expOut.opCode inside {opPushFlags, opPushPc, opPopPc}) begin
                stackSeen++;
            end
        end
    endtask

    // new inputs for the next edge, drawn at random only when asked
    task automatic driveInputs(input logic randomMode);
        redirect.interrupt   = 1'b0;
        redirect.ret         = 1'b0;
        redirect.jump        = 1'b0;
        redirect.jumpAddress = $urandom % 64;
        redirect.popAddress  = $urandom % 64;
        // stack request stays up until taken
        if (stackTaken) begin
            stackReq = '0;
        end
        if (!randomMode) begin
            stall     = 1'b0;
            stallLeft = 0;
        end else begin
            redirect.interrupt = ($urandom % 100) < 3;
            redirect.ret       = ($urandom % 100) < 3;
            redirect.jump      = ($urandom % 100) < 3;
            if (stackReq == '0 && ($urandom % 100) < 5) begin
                stackReq = 3'($urandom % 7 + 1);
                stackReg = 3'($urandom);
            end
            // occasional long stall bursts
            if (stallLeft > 0) begin
                stall = 1'b1;
                stallLeft--;
            end else if (($urandom % 100) < 2) begin
                stall     = 1'b1;
                stallLeft = 5 + $urandom % 20;
            end else begin
                stall = ($urandom % 100) < 20;
            end
        end
    endtask

    task automatic stepCycle(input logic randomMode);
        @(posedge clk);
        #1;
        modelEdge();
        checkOutputs();
        driveInputs(randomMode);
    endtask

    // step until outValid shows up or the limit runs out
    task automatic waitForOutput(input string what, input logic [31:0] firstPc);
        int waited;
        waited = 0;
        do begin
            stepCycle(1'b0);
            waited++;
        end while (!outValid && waited < waitLimit);
        if (!outValid) begin
            timeoutErrors++;
            $display("timeout: no decoded instruction appeared %s", what);
        end else begin
            checkField("pc", firstPc, out.pc);
        end
    endtask

    initial begin
        void'($urandom(32'h80fe));
        clk           = 1'b0;
        enable        = 1'b0;
        redirect      = '0;
        stackReq      = '0;
        stackReg      = 3'b000;
        stall         = 1'b0;
        checkErrors   = 0;
        timeoutErrors = 0;
        stallLeft     = 0;
        ldmSeen       = 0;
        stackSeen     = 0;
        modelPc       = resetVector;
        modelHalf     = 1'b0;
        expValid      = 1'b0;
        stackTaken    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        enable = 1'b1;

        // first word comes from the reset vector
        waitForOutput("after reset", resetVector);

        repeat (randomCycles) begin
            stepCycle(1'b1);
        end

        // all three redirects at once where the interrupt wins
        stepCycle(1'b0);
        redirect.interrupt = 1'b1;
        redirect.ret       = 1'b1;
        redirect.jump      = 1'b1;
        waitForOutput("after combined redirect", interruptVector);
        repeat (20) begin
            stepCycle(1'b0);
        end

        assert (ldmSeen > 0) else begin
            checkErrors++;
            $display("no load-immediate pair was decoded during the run");
        end
        assert (stackSeen > 0) else begin
            checkErrors++;
            $display("no injected stack instruction was decoded during the run");
        end

        $display("errors: %0d check failures, %0d timeouts", checkErrors, timeoutErrors);
        if (checkErrors == 0 && timeoutErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== program.hex ====
// one 16-bit instruction word per line, word addresses 0 to 31
// opcode in bits 15:11, then rs, rd and shamt; A0xx-A7xx words are ldm, the next word is its immediate
0949
1123
A120
BEEF
1A45
2066
A3E0
1234
0000
4100
0A8A
A240
00FF
12C3
1D0E
A060
8001
2211
0B0B
A5A0
7FFF
1FE1
0000
A300
C0DE
09C2
2410
A4E0
5A5A
137F
0820
A7E0

// ==== list.f ====
fetchPkg.sv
instructionMemory.sv
fetchStage.sv
fetchQueue.sv
instructionDecoder.sv
fetchTop.sv
fetchTb.sv
